// ==== common/dmem_pkg.sv ====
package dmem_pkg;

    localparam int LINE_BITS      = 256;
    localparam int WORDS_PER_LINE = 8;
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;   // byte offset within a line

    typedef logic [31:0] word_t;   // processor word
    typedef logic [63:0] beat_t;   // memory burst beat

    // one cache line, seen as words on the cache side and beats on the memory side
    typedef union packed {
        word_t [WORDS_PER_LINE-1:0] words;
        beat_t [BEATS_PER_LINE-1:0] beats;
    } line_u;

    typedef logic [LINE_BITS/8-1:0] line_mask_t;   // byte enables across a line

    // processor request, held until the response pulse
    typedef struct packed {
        logic       read;
        logic       write;
        word_t      addr;
        logic [3:0] mask;   // byte enables within the word
        word_t      wdata;
    } dmem_req_t;

    // burst memory request
    typedef struct packed {
        logic  read;    // one-cycle strobe
        logic  write;   // held until the last beat is taken
        word_t addr;    // line aligned
        beat_t wdata;   // current write beat
    } bmem_req_t;

endpackage

// ==== rtl/bus_adapter.sv ====
`timescale 1ns/1ps

module bus_adapter (
    input  dmem_pkg::dmem_req_t  req_i,
    output dmem_pkg::line_u      line_wdata_o,
    output dmem_pkg::line_mask_t line_mask_o,
    input  dmem_pkg::line_u      line_rdata_i,
    output dmem_pkg::word_t      rdata_o
);
    import dmem_pkg::*;

    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);

    logic [WSEL_BITS-1:0] word_sel;

    assign word_sel = req_i.addr[2 +: WSEL_BITS];   // addr bits 4:2

    // the write word goes into every slot, the mask picks the real one
    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line_wdata_o.words[i] = req_i.wdata;
        end
    end

    assign line_mask_o = line_mask_t'(req_i.mask) << {word_sel, 2'b00};   // 4 bytes per word

    assign rdata_o = line_rdata_i.words[word_sel];

endmodule

// ==== dcache/dcache_store.sv ====
`timescale 1ns/1ps

module dcache_store #(
    parameter int LOG2_SETS = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dmem_pkg::word_t      addr_i,
    input  logic                 sel_victim_i,
    input  logic                 store_write_i,
    input  logic                 fill_i,
    input  dmem_pkg::line_u      wdata_i,
    input  dmem_pkg::line_mask_t mask_i,
    input  dmem_pkg::line_u      fill_line_i,
    output logic                 hit_o,
    output logic                 dirty_o,
    output dmem_pkg::line_u      rdata_o,
    output dmem_pkg::word_t      mem_addr_o
);
    import dmem_pkg::*;

    localparam int SETS     = 1 << LOG2_SETS;
    localparam int TAG_BITS = 32 - LOG2_SETS - OFFSET_BITS;

    logic [TAG_BITS-1:0]  tag_q [SETS];
    line_u                data_q [SETS];
    logic [SETS-1:0]      valid_q;
    logic [SETS-1:0]      dirty_q;

    logic [TAG_BITS-1:0]  tag;
    logic [LOG2_SETS-1:0] idx;
    line_u                merged;

    assign tag = addr_i[31 -: TAG_BITS];
    assign idx = addr_i[OFFSET_BITS +: LOG2_SETS];

    assign hit_o   = valid_q[idx] && (tag_q[idx] == tag);
    assign dirty_o = valid_q[idx] && dirty_q[idx];   // victim needs write-back
    assign rdata_o = data_q[idx];

    // victim address during write-back, request line otherwise
    assign mem_addr_o = sel_victim_i ? {tag_q[idx], idx, {OFFSET_BITS{1'b0}}}
                                     : {tag, idx, {OFFSET_BITS{1'b0}}};

    always_comb begin
        merged = data_q[idx];
        for (int b = 0; b < LINE_BITS/8; b++) begin
            if (mask_i[b]) begin
                merged[b*8 +: 8] = wdata_i[b*8 +: 8];   // enabled bytes only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;   // clean copy of memory
        end else if (store_write_i) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= fill_line_i;
        end else if (store_write_i) begin
            data_q[idx] <= merged;
        end
    end

    // the controller only writes a line that is present
    assert property (@(posedge clk) disable iff (rst) store_write_i |-> hit_o);

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic read_i,
    input  logic write_i,
    input  logic hit_i,
    input  logic dirty_i,
    input  logic line_resp_i,
    output logic store_write_o,
    output logic fill_o,
    output logic sel_victim_o,
    output logic line_read_o,
    output logic line_write_o,
    output logic resp_o
);

    typedef enum logic [1:0] {
        S_COMPARE,
        S_WRITEBACK,
        S_FILL,
        S_RESPOND
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   req;

    assign req = read_i || write_i;

    always_comb begin
        state_d       = state_q;
        store_write_o = 1'b0;
        fill_o        = 1'b0;
        sel_victim_o  = 1'b0;
        line_read_o   = 1'b0;
        line_write_o  = 1'b0;
        resp_o        = 1'b0;
        case (state_q)
            S_COMPARE: begin
                if (req) begin
                    if (hit_i) begin
                        store_write_o = write_i;   // masked merge on a write hit
                        state_d       = S_RESPOND;
                    end else if (dirty_i) begin
                        state_d = S_WRITEBACK;
                    end else begin
                        state_d = S_FILL;
                    end
                end
            end
            S_WRITEBACK: begin
                sel_victim_o = 1'b1;
                line_write_o = 1'b1;
                if (line_resp_i) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                line_read_o = 1'b1;
                if (line_resp_i) begin
                    fill_o  = 1'b1;       // line data valid with the response
                    state_d = S_COMPARE;  // recompare, hit path serves it
                end
            end
            S_RESPOND: begin
                resp_o  = 1'b1;
                state_d = S_COMPARE;
            end
            default: state_d = S_COMPARE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_COMPARE;
        end else begin
            state_q <= state_d;
        end
    end

    // the response closes a request that was held through the compare cycle
    assert property (@(posedge clk) disable iff (rst)
        resp_o |-> (read_i || write_i) && $past(read_i || write_i));

endmodule

// ==== rtl/cacheline_adaptor.sv ====
`timescale 1ns/1ps

module cacheline_adaptor (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_read_i,
    input  logic                line_write_i,
    input  dmem_pkg::word_t     line_addr_i,
    input  dmem_pkg::line_u     line_wdata_i,
    output dmem_pkg::line_u     line_rdata_o,
    output logic                line_resp_o,
    output dmem_pkg::bmem_req_t bmem_req_o,
    input  dmem_pkg::beat_t     bmem_rdata_i,
    input  logic                bmem_resp_i
);
    import dmem_pkg::*;

    localparam int CNT_BITS = $clog2(BEATS_PER_LINE);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_BEATS,
        S_WR_BEATS,
        S_DONE
    } state_e;

    state_e              state_q;
    logic [CNT_BITS-1:0] beat_q;
    line_u               line_q;
    logic                last_beat;

    assign last_beat = (beat_q == CNT_BITS'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    beat_q <= '0;
                    if (line_read_i) begin
                        state_q <= S_RD_REQ;
                    end else if (line_write_i) begin
                        state_q <= S_WR_BEATS;
                    end
                end
                S_RD_REQ: state_q <= S_RD_BEATS;   // read strobe lasts one cycle
                S_RD_BEATS, S_WR_BEATS: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_DONE: state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // beats land lowest first
    always_ff @(posedge clk) begin
        if (state_q == S_RD_BEATS && bmem_resp_i) begin
            line_q.beats[beat_q] <= bmem_rdata_i;
        end
    end

    assign line_rdata_o = line_q;
    assign line_resp_o  = (state_q == S_DONE);

    assign bmem_req_o.read  = (state_q == S_RD_REQ);
    assign bmem_req_o.write = (state_q == S_WR_BEATS);
    assign bmem_req_o.addr  = line_addr_i;
    assign bmem_req_o.wdata = line_wdata_i.beats[beat_q];   // current write beat

    // memory answers only inside a burst
    assert property (@(posedge clk) disable iff (rst)
        bmem_resp_i |-> (state_q == S_RD_BEATS || state_q == S_WR_BEATS));

endmodule

// ==== rtl/dmem_subsys.sv ====
`timescale 1ns/1ps

module dmem_subsys #(
    parameter int LOG2_SETS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  dmem_pkg::dmem_req_t dmem_req_i,
    output dmem_pkg::word_t     dmem_rdata_o,
    output logic                dmem_resp_o,
    output dmem_pkg::bmem_req_t bmem_req_o,
    input  dmem_pkg::beat_t     bmem_rdata_i,
    input  logic                bmem_resp_i
);
    import dmem_pkg::*;

    line_u      cpu_wdata;    // adapter -> store
    line_mask_t cpu_mask;     // adapter -> store
    line_u      cache_rdata;  // store -> adapter, adaptor
    word_t      line_addr;    // store -> adaptor
    line_u      line_rdata;   // adaptor -> store
    logic       line_resp;
    logic       line_read;
    logic       line_write;
    logic       hit;
    logic       dirty;
    logic       store_write;
    logic       fill;
    logic       sel_victim;

    bus_adapter u_bus_adapter (
        .req_i        (dmem_req_i),
        .line_wdata_o (cpu_wdata),
        .line_mask_o  (cpu_mask),
        .line_rdata_i (cache_rdata),
        .rdata_o      (dmem_rdata_o)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .read_i        (dmem_req_i.read),
        .write_i       (dmem_req_i.write),
        .hit_i         (hit),
        .dirty_i       (dirty),
        .line_resp_i   (line_resp),
        .store_write_o (store_write),
        .fill_o        (fill),
        .sel_victim_o  (sel_victim),
        .line_read_o   (line_read),
        .line_write_o  (line_write),
        .resp_o        (dmem_resp_o)
    );

    dcache_store #(
        .LOG2_SETS (LOG2_SETS)
    ) u_dcache_store (
        .clk           (clk),
        .rst           (rst),
        .addr_i        (dmem_req_i.addr),
        .sel_victim_i  (sel_victim),
        .store_write_i (store_write),
        .fill_i        (fill),
        .wdata_i       (cpu_wdata),
        .mask_i        (cpu_mask),
        .fill_line_i   (line_rdata),
        .hit_o         (hit),
        .dirty_o       (dirty),
        .rdata_o       (cache_rdata),
        .mem_addr_o    (line_addr)
    );

    cacheline_adaptor u_cacheline_adaptor (
        .clk          (clk),
        .rst          (rst),
        .line_read_i  (line_read),
        .line_write_i (line_write),
        .line_addr_i  (line_addr),
        .line_wdata_i (cache_rdata),   // victim line during write-back
        .line_rdata_o (line_rdata),
        .line_resp_o  (line_resp),
        .bmem_req_o   (bmem_req_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule

// ==== dv/bmem_model.sv ====
`timescale 1ns/1ps

module bmem_model #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                rst,
    input  dmem_pkg::bmem_req_t req_i,
    output dmem_pkg::beat_t     rdata_o,
    output logic                resp_o
);
    import dmem_pkg::*;

    word_t  mem [MEM_WORDS];
    integer seed;

    function automatic int word_index(input word_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    // 0 to 2 idle cycles before the next beat
    task automatic beat_gap();
        int gap;
        gap = $unsigned($random(seed)) % 3;
        #1;
        resp_o = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        word_t line_addr;
        beat_t beat;
        int    w;
        seed    = 32'hd80c;
        rdata_o = '0;
        resp_o  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'hffff_0000;   // address, upper half inverted
        end
        forever begin
            @(posedge clk);
            if (!rst && req_i.read) begin
                line_addr = req_i.addr;
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    beat_gap();
                    w       = word_index(line_addr + word_t'(8 * k));
                    rdata_o = {mem[w + 1], mem[w]};
                    resp_o  = 1'b1;
                    @(posedge clk);   // beat taken here
                end
                #1;
                resp_o = 1'b0;
            end else if (!rst && req_i.write) begin
                line_addr = req_i.addr;
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    beat_gap();
                    beat   = req_i.wdata;   // beat accepted at the next edge
                    resp_o = 1'b1;
                    @(posedge clk);
                    w          = word_index(line_addr + word_t'(8 * k));
                    mem[w]     = beat[31:0];
                    mem[w + 1] = beat[63:32];
                end
                #1;
                resp_o = 1'b0;
            end
        end
    end

endmodule

// ==== dv/tb_dmem_subsys.sv ====
`timescale 1ns/1ps

module tb_dmem_subsys;
    import dmem_pkg::*;

    localparam int LOG2_SETS  = 3;
    localparam int MEM_WORDS  = 1024;
    localparam int RAND_OPS   = 200;
    localparam int OP_CYCLES  = 2 * BEATS_PER_LINE * 3 + 10;   // write-back and fill at slowest beats
    localparam int MAX_CYCLES = 3 * (RAND_OPS + 20) * OP_CYCLES;

    logic      clk;
    logic      rst;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      dmem_resp;
    bmem_req_t bmem_req;
    beat_t     bmem_rdata;
    logic      bmem_resp;

    word_t     shadow [MEM_WORDS];   // processor view of memory
    beat_t     wb_beats [$];
    word_t     wb_addrs [$];
    int        rd_bursts;
    int        cycles;
    int        errors;
    int        checks;
    int        tests;
    integer    seed;

    dmem_subsys #(
        .LOG2_SETS (LOG2_SETS)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .dmem_req_i   (dmem_req),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .bmem_req_o   (bmem_req),
        .bmem_rdata_i (bmem_rdata),
        .bmem_resp_i  (bmem_resp)
    );

    bmem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) u_bmem (
        .clk     (clk),
        .rst     (rst),
        .req_i   (bmem_req),
        .rdata_o (bmem_rdata),
        .resp_o  (bmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // memory side traffic sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (bmem_req.read) begin
                rd_bursts++;
            end
            if (bmem_req.write && bmem_resp) begin
                wb_beats.push_back(bmem_req.wdata);
                wb_addrs.push_back(bmem_req.addr);
            end
        end
    end

    function automatic int widx(input word_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic word_t merge_word(input word_t old, input word_t data,
                                         input logic [3:0] mask);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // drives one request just after a rising edge and holds it until the response
    task automatic access(input logic wr, input word_t addr, input logic [3:0] mask,
                          input word_t wdata, output word_t rdata, output int latency);
        int waited;
        waited         = 0;
        dmem_req.read  = ~wr;
        dmem_req.write = wr;
        dmem_req.addr  = addr;
        dmem_req.mask  = mask;
        dmem_req.wdata = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!dmem_resp);
        rdata   = dmem_rdata;
        latency = waited - 1;   // first negedge comes before the sampling edge
        @(posedge clk);
        #1;
        dmem_req = '0;
        if (wr) begin
            shadow[widx(addr)] = merge_word(shadow[widx(addr)], wdata, mask);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("reset", 0, dmem_resp);
        check("reset", 0, bmem_req.read);
        check("reset", 0, bmem_req.write);
        @(posedge clk);
        #1;
        report_test("reset", e0);
    endtask

    task automatic test_read_miss();
        int    e0;
        int    bursts;
        int    lat;
        word_t rdata;
        e0     = errors;
        bursts = rd_bursts;
        access(1'b0, 32'h104, 4'h0, '0, rdata, lat);
        check("read_miss", shadow[widx(32'h104)], rdata);
        check("read_miss", 1, rd_bursts - bursts);
        check("read_miss", 0, wb_beats.size());   // nothing to write back from a cold line
        report_test("read_miss", e0);
    endtask

    task automatic test_read_hit();
        int    e0;
        int    bursts;
        int    lat;
        word_t rdata;
        e0     = errors;
        bursts = rd_bursts;
        access(1'b0, 32'h10c, 4'h0, '0, rdata, lat);
        check("read_hit", shadow[widx(32'h10c)], rdata);
        check("read_hit", 0, rd_bursts - bursts);
        check("read_hit", 1, lat);
        report_test("read_hit", e0);
    endtask

    task automatic test_masked_write();
        int    e0;
        int    lat;
        word_t rdata;
        word_t expected;
        e0       = errors;
        expected = merge_word(shadow[widx(32'h108)], 32'ha5a5_5a5a, 4'b0101);
        access(1'b1, 32'h108, 4'b0101, 32'ha5a5_5a5a, rdata, lat);
        check("masked_write", 1, lat);
        access(1'b0, 32'h108, 4'h0, '0, rdata, lat);
        check("masked_write", expected, rdata);
        report_test("masked_write", e0);
    endtask

    task automatic test_eviction();
        int    e0;
        int    bursts;
        int    lat;
        int    base;
        word_t rdata;
        e0   = errors;
        base = widx(32'h100);
        access(1'b1, 32'h100, 4'hf, 32'h1234_5678, rdata, lat);   // line 0x100 now dirty
        wb_beats.delete();
        wb_addrs.delete();
        bursts = rd_bursts;
        access(1'b0, 32'h304, 4'h0, '0, rdata, lat);   // same set with another tag
        check("eviction", shadow[widx(32'h304)], rdata);
        check("eviction", 1, rd_bursts - bursts);
        check("eviction", BEATS_PER_LINE, wb_beats.size());
        for (int k = 0; k < wb_beats.size() && k < BEATS_PER_LINE; k++) begin
            check("eviction", {shadow[base + 2*k + 1], shadow[base + 2*k]}, wb_beats[k]);
            check("eviction", 32'h100, wb_addrs[k]);
        end
        access(1'b0, 32'h100, 4'h0, '0, rdata, lat);
        check("eviction", shadow[widx(32'h100)], rdata);
        report_test("eviction", e0);
    endtask

    task automatic test_random_mix();
        int         e0;
        int         lat;
        word_t      op;
        word_t      addr;
        word_t      wdata;
        word_t      rdata;
        logic [3:0] mask;
        e0 = errors;
        for (int n = 0; n < RAND_OPS; n++) begin
            op    = $random(seed);
            addr  = op & 32'h0000_03fc;   // 1 KB range is four times the cache
            mask  = op[15:12];
            wdata = $random(seed);
            if (op[31]) begin
                access(1'b1, addr, mask, wdata, rdata, lat);
            end else begin
                access(1'b0, addr, 4'h0, '0, rdata, lat);
                check("random_mix", shadow[widx(addr)], rdata);
            end
        end
        report_test("random_mix", e0);
    endtask

    initial begin
        rst       = 1'b1;
        dmem_req  = '0;
        rd_bursts = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        seed      = 32'hd80c;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_t'(i * 4) ^ 32'hffff_0000;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_read_miss();
        test_read_hit();
        test_masked_write();
        test_eviction();
        test_random_mix();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/dmem_pkg.sv
rtl/bus_adapter.sv
dcache/dcache_store.sv
dcache/dcache_ctrl.sv
rtl/cacheline_adaptor.sv
rtl/dmem_subsys.sv
dv/bmem_model.sv
dv/tb_dmem_subsys.sv
